//--- design/calc_pkg.sv
// Shared widths, timing constants and command types for the calculator controller
// Queue depth must stay a power of two, the pointers wrap naturally

package calc_pkg;

  // ==========================================================================
  // Widths and limits
  // ==========================================================================
  localparam int mat_id_w        = 6;   // Matrix ID bits
  localparam int dim_w           = 3;   // Row or column count bits
  localparam int rx_id_limit     = 32;  // First UART byte that is refused
  localparam int cmd_queue_depth = 4;
  localparam int cmd_ptr_w       = $clog2(cmd_queue_depth);
  localparam int cmd_cnt_w       = $clog2(cmd_queue_depth + 1);  // Holds 0..depth
  localparam int err_hold_cycles = 64;  // calc_err high time after a failure
  localparam int err_timer_w     = $clog2(err_hold_cycles);
  localparam int cycle_cnt_w     = 16;  // ALU cycle measurement, saturating

  // ==========================================================================
  // Types
  // ==========================================================================
  typedef enum logic [2:0] {
    op_none,
    op_add,
    op_mat_mul,
    op_scalar_mul,
    op_transpose,
    op_conv
  } op_code_t;

  // Operand shapes seen by the dimension check
  typedef struct packed {
    logic [dim_w-1:0] a_rows;
    logic [dim_w-1:0] a_cols;
    logic [dim_w-1:0] b_rows;
    logic [dim_w-1:0] b_cols;
  } mat_dims_t;

  // One queued command, 35 bits
  typedef struct packed {
    op_code_t            op;
    logic [mat_id_w-1:0] id_a;
    logic [mat_id_w-1:0] id_b;
    logic [7:0]          scalar;  // Two's complement
    mat_dims_t           dims;
  } calc_cmd_t;

endpackage

//--- design/calc_cmd_if.sv
// Command stream between entry, queue and dispatcher
// Transfer on a rising edge with valid and ready both high, fields held while stalled

`timescale 1ns/1ps

interface calc_cmd_if;
  import calc_pkg::*;

  logic                valid;
  logic                ready;
  op_code_t            op;
  logic [mat_id_w-1:0] id_a;
  logic [mat_id_w-1:0] id_b;
  logic [7:0]          scalar;
  mat_dims_t           dims;

  // Producer side
  modport source (
    output valid, op, id_a, id_b, scalar, dims,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid, op, id_a, id_b, scalar, dims,
    output ready
  );

endinterface

//--- design/cmd_entry.sv
// Operator entry FSM, one command per pass from switch select to queue handoff
// Buttons are assumed already debounced, only rising edges are used

`timescale 1ns/1ps

module cmd_entry (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          sw_mode_sel,
  input  logic [7:0]          scalar_sw,
  input  logic [7:0]          rx_data,
  input  logic                rx_done,
  input  logic                btn_confirm,
  input  logic                btn_esc,
  input  calc_pkg::mat_dims_t dims,
  calc_cmd_if.source          cmd,
  output logic                entry_busy
);
  import calc_pkg::*;

  typedef enum logic [2:0] {
    select_op,
    wait_id_a,
    wait_id_b,
    wait_scalar,
    offer
  } entry_state_t;

  entry_state_t        state;
  op_code_t            op_q;
  op_code_t            op_dec;
  logic [mat_id_w-1:0] id_a_q;
  logic [mat_id_w-1:0] id_b_q;
  logic [mat_id_w-1:0] rx_id;
  logic [7:0]          scalar_q;
  logic [7:0]          scalar_tc;
  mat_dims_t           dims_q;
  logic                confirm_prev, esc_prev;
  logic                confirm_edge, esc_edge;
  logic                rx_ok;
  logic                need_b;
  logic                pick_op, take_a, take_b, take_s, enter_offer;

  // ==========================================================================
  // Input conditioning
  // ==========================================================================
  assign confirm_edge = btn_confirm & ~confirm_prev;
  assign esc_edge     = btn_esc & ~esc_prev;

  assign rx_ok = rx_done && (rx_data < 8'(rx_id_limit));  // Bytes of 32 or more dropped
  assign rx_id = rx_data[mat_id_w-1:0];

  // Switch priority, highest switch wins
  always_comb begin
    if (sw_mode_sel[7])      op_dec = op_add;
    else if (sw_mode_sel[6]) op_dec = op_mat_mul;
    else if (sw_mode_sel[5]) op_dec = op_scalar_mul;
    else if (sw_mode_sel[4]) op_dec = op_transpose;
    else if (sw_mode_sel[3]) op_dec = op_conv;
    else                     op_dec = op_none;
  end

  // Sign-magnitude switches to two's complement, negative zero gives 0
  assign scalar_tc = scalar_sw[7] ? (8'd0 - {1'b0, scalar_sw[6:0]})
                                  : {1'b0, scalar_sw[6:0]};

  // ==========================================================================
  // Step strobes, escape wins over confirm and UART
  // ==========================================================================
  assign need_b  = (op_q == op_add) || (op_q == op_mat_mul);
  assign pick_op = (state == select_op) && !esc_edge && confirm_edge && (op_dec != op_none);
  assign take_a  = (state == wait_id_a) && !esc_edge && rx_ok;
  assign take_b  = (state == wait_id_b) && !esc_edge && rx_ok;
  assign take_s  = (state == wait_scalar) && !esc_edge && confirm_edge;

  // Last operand of the op taken
  assign enter_offer = take_b || take_s ||
                       (take_a && !need_b && (op_q != op_scalar_mul));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= select_op;
      op_q         <= op_none;
      confirm_prev <= 1'b0;
      esc_prev     <= 1'b0;
    end else begin
      confirm_prev <= btn_confirm;  // Edges during offer are simply lost
      esc_prev     <= btn_esc;
      case (state)
        select_op: begin
          if (pick_op) begin
            op_q  <= op_dec;
            state <= wait_id_a;
          end
        end
        wait_id_a: begin
          if (esc_edge)                   state <= select_op;
          else if (enter_offer)           state <= offer;
          else if (take_a && need_b)      state <= wait_id_b;
          else if (take_a)                state <= wait_scalar;  // Scalar multiply
        end
        wait_id_b: begin
          if (esc_edge)    state <= wait_id_a;  // Back one step only
          else if (take_b) state <= offer;
        end
        wait_scalar: begin
          if (esc_edge)    state <= select_op;
          else if (take_s) state <= offer;
        end
        offer: begin
          if (cmd.ready) state <= select_op;  // Handed to the queue
        end
        default: state <= select_op;
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (pick_op) scalar_q <= 8'd0;  // Only scalar multiply carries a scalar
    if (take_a) begin
      id_a_q <= rx_id;
      id_b_q <= (op_q == op_conv) ? rx_id : '0;  // Kernel goes to operand B too
    end
    if (take_b)      id_b_q   <= rx_id;
    if (take_s)      scalar_q <= scalar_tc;
    if (enter_offer) dims_q   <= dims;
  end

  assign cmd.valid  = (state == offer);
  assign cmd.op     = op_q;
  assign cmd.id_a   = id_a_q;
  assign cmd.id_b   = id_b_q;
  assign cmd.scalar = scalar_q;
  assign cmd.dims   = dims_q;
  assign entry_busy = (state == offer);  // Back-pressure seen by the operator

endmodule

//--- design/cmd_queue.sv
// Small command FIFO between operator entry and ALU dispatch
// Output fields come straight from storage, no read latency

`timescale 1ns/1ps

module cmd_queue (
  input  logic        clk,
  input  logic        rst_n,
  calc_cmd_if.sink    push_side,
  calc_cmd_if.source  pop_side
);
  import calc_pkg::*;

  calc_cmd_t            mem [cmd_queue_depth];
  calc_cmd_t            wr_cmd;
  calc_cmd_t            rd_cmd;
  logic [cmd_ptr_w-1:0] wr_ptr;
  logic [cmd_ptr_w-1:0] rd_ptr;
  logic [cmd_cnt_w-1:0] count;
  logic                 push, pop;

  assign push = push_side.valid && push_side.ready;
  assign pop  = pop_side.valid && pop_side.ready;

  // Pack incoming fields
  assign wr_cmd = '{op:     push_side.op,
                    id_a:   push_side.id_a,
                    id_b:   push_side.id_b,
                    scalar: push_side.scalar,
                    dims:   push_side.dims};

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_cmd;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  assign push_side.ready = (count != cmd_cnt_w'(cmd_queue_depth));  // Low only when full

  assign rd_cmd          = mem[rd_ptr];
  assign pop_side.valid  = (count != '0);
  assign pop_side.op     = rd_cmd.op;
  assign pop_side.id_a   = rd_cmd.id_a;
  assign pop_side.id_b   = rd_cmd.id_b;
  assign pop_side.scalar = rd_cmd.scalar;
  assign pop_side.dims   = rd_cmd.dims;

endmodule

//--- design/alu_dispatch.sv
// Takes one command at a time, checks shapes, runs the ALU start/done handshake
// Cycle count saturates, done and error counters wrap at 8 bits

`timescale 1ns/1ps

module alu_dispatch (
  input  logic                               clk,
  input  logic                               rst_n,
  calc_cmd_if.sink                           cmd,
  output logic                               alu_start,
  output calc_pkg::op_code_t                 alu_op,
  output logic [calc_pkg::mat_id_w-1:0]      alu_id_a,
  output logic [calc_pkg::mat_id_w-1:0]      alu_id_b,
  output logic [7:0]                         alu_scalar,
  input  logic                               alu_done,
  input  logic                               alu_err,
  output logic                               calc_err,
  output logic [calc_pkg::cycle_cnt_w-1:0]   last_cycles,
  output logic [7:0]                         done_count,
  output logic [7:0]                         err_count
);
  import calc_pkg::*;

  typedef enum logic [1:0] {
    idle,
    hold_check,
    run
  } disp_state_t;

  disp_state_t            state;
  mat_dims_t              dims_q;
  logic [cycle_cnt_w-1:0] cyc_cnt;
  logic [cycle_cnt_w-1:0] cyc_nxt;
  logic [err_timer_w-1:0] err_timer;
  logic                   take, dims_ok, fail;

  assign cmd.ready = (state == idle);
  assign take      = cmd.valid && cmd.ready;

  // Shape rule per op, everything else passes
  always_comb begin
    case (alu_op)
      op_add:     dims_ok = (dims_q.a_rows == dims_q.b_rows) &&
                            (dims_q.a_cols == dims_q.b_cols);
      op_mat_mul: dims_ok = (dims_q.a_cols == dims_q.b_rows);
      default:    dims_ok = 1'b1;
    endcase
  end

  // Rejection or ALU error both start the hold
  assign fail    = ((state == hold_check) && !dims_ok) || ((state == run) && alu_err);
  assign cyc_nxt = (cyc_cnt == '1) ? cyc_cnt : cyc_cnt + 1'b1;  // Saturate

  // Operands stay put from take until the next take
  always_ff @(posedge clk) begin
    if (take) begin
      alu_op     <= cmd.op;
      alu_id_a   <= cmd.id_a;
      alu_id_b   <= cmd.id_b;
      alu_scalar <= cmd.scalar;
      dims_q     <= cmd.dims;
    end
  end

  // ==========================================================================
  // Handshake FSM and measurement
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= idle;
      alu_start   <= 1'b0;
      cyc_cnt     <= '0;
      last_cycles <= '0;
      done_count  <= '0;
      err_count   <= '0;
    end else begin
      alu_start <= 1'b0;  // One-cycle pulse
      case (state)
        idle: begin
          if (take) state <= hold_check;
        end
        hold_check: begin
          if (dims_ok) begin
            alu_start <= 1'b1;
            cyc_cnt   <= '0;
            state     <= run;
          end else begin
            err_count <= err_count + 1'b1;
            state     <= idle;  // ALU never sees it
          end
        end
        run: begin
          if (alu_err) begin
            err_count <= err_count + 1'b1;
            state     <= idle;
          end else if (alu_done) begin
            last_cycles <= cyc_nxt;  // Edges from start pulse to done
            done_count  <= done_count + 1'b1;
            state       <= idle;
          end else begin
            cyc_cnt <= cyc_nxt;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Error flag hold, a new failure restarts the window
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      calc_err  <= 1'b0;
      err_timer <= '0;
    end else if (fail) begin
      calc_err  <= 1'b1;
      err_timer <= '0;
    end else if (calc_err) begin
      if (err_timer == err_timer_w'(err_hold_cycles - 1)) calc_err <= 1'b0;
      err_timer <= err_timer + 1'b1;
    end
  end

endmodule

//--- design/matrix_calc_ctrl.sv
// Calculator control top, entry feeds a 4-deep queue that feeds the ALU dispatcher
// Dimension inputs are sampled when a command completes, not when it runs

`timescale 1ns/1ps

module matrix_calc_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  // Operator side
  input  logic [7:0]                       sw_mode_sel,
  input  logic [7:0]                       scalar_sw,
  input  logic [7:0]                       rx_data,
  input  logic                             rx_done,
  input  logic                             btn_confirm,
  input  logic                             btn_esc,
  input  logic [calc_pkg::dim_w-1:0]       a_rows,
  input  logic [calc_pkg::dim_w-1:0]       a_cols,
  input  logic [calc_pkg::dim_w-1:0]       b_rows,
  input  logic [calc_pkg::dim_w-1:0]       b_cols,
  output logic                             entry_busy,
  // ALU side
  output logic                             alu_start,
  output calc_pkg::op_code_t               alu_op,
  output logic [calc_pkg::mat_id_w-1:0]    alu_id_a,
  output logic [calc_pkg::mat_id_w-1:0]    alu_id_b,
  output logic [7:0]                       alu_scalar,
  input  logic                             alu_done,
  input  logic                             alu_err,
  // Status
  output logic                             calc_err,
  output logic [calc_pkg::cycle_cnt_w-1:0] last_cycles,
  output logic [7:0]                       done_count,
  output logic [7:0]                       err_count
);
  import calc_pkg::*;

  mat_dims_t dims_in;

  assign dims_in = '{a_rows: a_rows, a_cols: a_cols, b_rows: b_rows, b_cols: b_cols};

  calc_cmd_if entry_q ();  // Entry to queue
  calc_cmd_if queue_d ();  // Queue to dispatcher

  cmd_entry u_entry (
    .clk, .rst_n, .sw_mode_sel, .scalar_sw, .rx_data, .rx_done,
    .btn_confirm, .btn_esc, .dims(dims_in), .cmd(entry_q.source), .entry_busy
  );

  cmd_queue u_queue (
    .clk, .rst_n, .push_side(entry_q.sink), .pop_side(queue_d.source)
  );

  alu_dispatch u_dispatch (
    .clk, .rst_n, .cmd(queue_d.sink), .alu_start, .alu_op, .alu_id_a, .alu_id_b,
    .alu_scalar, .alu_done, .alu_err, .calc_err, .last_cycles, .done_count, .err_count
  );

endmodule

//--- test/calc_ctrl_assert.sv
// Handshake properties on the controller top, attached by bind
// Assumes the ALU never answers in the same cycle as alu_start

`timescale 1ns/1ps

module calc_ctrl_assert (
  input logic clk,
  input logic rst_n,
  input logic alu_start,
  input logic alu_done,
  input logic alu_err,
  input logic calc_err
);

  logic pending;  // Start seen, no answer yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (alu_start) begin
      pending <= 1'b1;
    end else if (alu_done || alu_err) begin
      pending <= 1'b0;  // Either answer closes the job
    end
  end

  // ==========================================================================
  // Properties
  // ==========================================================================
  start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    alu_start |=> !alu_start)
    else $error("alu_start held for more than one cycle");

  start_not_overlapped: assert property (@(posedge clk) disable iff (!rst_n)
    alu_start |-> !pending)
    else $error("alu_start issued while the previous job was unanswered");

  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (!alu_start && !calc_err))
    else $error("alu_start or calc_err high when reset was released");

endmodule

bind matrix_calc_ctrl calc_ctrl_assert u_assert (
  .clk(clk),
  .rst_n(rst_n),
  .alu_start(alu_start),
  .alu_done(alu_done),
  .alu_err(alu_err),
  .calc_err(calc_err)
);

//--- test/tb_matrix_calc_ctrl.sv
// Random operator and ALU model, every dispatch checked in order against a command model
// One operator action per two cycles, dimension inputs held for a whole command

`timescale 1ns/1ps

module tb_matrix_calc_ctrl;
  import calc_pkg::*;

  localparam int seed           = 32'h60f3;
  localparam int n_rand         = 40;   // Noisy entry, random ALU latency
  localparam int n_fast         = 16;   // Clean entry, slowest ALU
  localparam int max_delay      = 20;
  localparam int cycles_per_cmd = 400;

  typedef enum {m_select, m_id_a, m_id_b, m_scalar, m_done} mirror_t;

  logic                   clk, rst_n;
  logic [7:0]             sw_mode_sel, scalar_sw, rx_data;
  logic                   rx_done, btn_confirm, btn_esc;
  logic [dim_w-1:0]       a_rows, a_cols, b_rows, b_cols;
  logic                   entry_busy;
  logic                   alu_start;
  op_code_t               alu_op;
  logic [mat_id_w-1:0]    alu_id_a, alu_id_b;
  logic [7:0]             alu_scalar;
  logic                   alu_done, alu_err, calc_err;
  logic [cycle_cnt_w-1:0] last_cycles;
  logic [7:0]             done_count, err_count;

  calc_cmd_t exp_q[$];            // Commands in entry order
  mat_dims_t cur_dims;
  string     test_name = "reset";
  bit        fast_mode, saw_stall;
  int        n_done, n_err, n_checked;
  int        n_started, n_passed;  // Start pulses seen, commands that should start

  matrix_calc_ctrl DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Count every start pulse, one cycle wide
  always @(negedge clk) begin
    if (alu_start) n_started++;
  end

  // ==========================================================================
  // Model helpers
  // ==========================================================================
  task automatic check_eq(input string what, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("error %s %s expected 0x%0h actual 0x%0h", test_name, what, exp_v, act_v);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch on %s", what);
    end
  endtask

  // Highest switch wins, package enum lists ops in that order
  function automatic op_code_t decode_switches(input logic [7:0] sw);
    for (int i = 0; i < 5; i++) begin
      if (sw[7-i]) return op_code_t'(3'(i + 1));
    end
    return op_none;
  endfunction

  function automatic logic [7:0] to_twos(input logic [7:0] sm);
    int mag;
    mag = int'(sm[6:0]);
    return sm[7] ? 8'(-mag) : 8'(mag);  // Negative zero lands on 0
  endfunction

  function automatic bit dims_pass(input calc_cmd_t c);
    if (c.op == op_add)
      return (c.dims.a_rows == c.dims.b_rows) && (c.dims.a_cols == c.dims.b_cols);
    if (c.op == op_mat_mul) return c.dims.a_cols == c.dims.b_rows;
    return 1'b1;
  endfunction

  // One operator action, waits out back-pressure first
  task automatic press(input logic [7:0] sw, input logic [7:0] scal, input logic [7:0] rxd,
                       input logic rxv, input logic conf, input logic esc);
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk);
    while (entry_busy) begin
      busy_cycles++;
      @(negedge clk);
    end
    if (busy_cycles > 1) saw_stall = 1'b1;  // Queue was full
    @(posedge clk);
    sw_mode_sel <= sw;
    scalar_sw   <= scal;
    rx_data     <= rxd;
    rx_done     <= rxv;
    btn_confirm <= conf;
    btn_esc     <= esc;
    a_rows      <= cur_dims.a_rows;
    a_cols      <= cur_dims.a_cols;
    b_rows      <= cur_dims.b_rows;
    b_cols      <= cur_dims.b_cols;
    @(posedge clk);
    rx_done     <= 1'b0;  // Buttons released so each press is one edge
    btn_confirm <= 1'b0;
    btn_esc     <= 1'b0;
  endtask

  // Walks the entry rules on a mirror state until one command is complete
  task automatic enter_command();
    calc_cmd_t  c;
    mirror_t    st;
    logic [7:0] sw, byte_v;
    int         pick, shape;
    c  = '0;
    st = m_select;
    cur_dims.a_rows = dim_w'($urandom_range(1, 3));
    cur_dims.a_cols = fast_mode ? cur_dims.a_rows : dim_w'($urandom_range(1, 3));
    shape = fast_mode ? 0 : $urandom_range(0, 3);
    cur_dims.b_rows = (shape == 0) ? cur_dims.a_rows :
                      (shape == 1) ? cur_dims.a_cols : dim_w'($urandom_range(1, 3));
    cur_dims.b_cols = (shape == 0) ? cur_dims.a_cols : dim_w'($urandom_range(1, 3));
    while (st != m_done) begin
      pick = fast_mode ? 9 : $urandom_range(0, 9);
      if (pick == 0) begin
        press(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1);  // Escape
        st = (st == m_id_b) ? m_id_a : m_select;
      end else if (pick == 1 && (st == m_id_a || st == m_id_b)) begin
        byte_v = 8'($urandom_range(rx_id_limit, 255));
        press(8'h00, 8'h00, byte_v, 1'b1, 1'b0, 1'b0);  // Refused byte
      end else if (pick == 2 && st == m_select) begin
        sw = 8'($urandom_range(0, 7));
        press(sw, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);  // No op switch
      end else if (st == m_select) begin
        sw = 8'($urandom_range(8, 255));
        press(sw, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        c.op     = decode_switches(sw);
        c.scalar = '0;
        st       = m_id_a;
      end else if (st == m_id_a) begin
        byte_v = 8'($urandom_range(0, rx_id_limit - 1));
        press(8'h00, 8'h00, byte_v, 1'b1, 1'b0, 1'b0);
        c.id_a = mat_id_w'(byte_v);
        c.id_b = (c.op == op_conv) ? mat_id_w'(byte_v) : '0;  // Kernel copied to B
        if (c.op == op_add || c.op == op_mat_mul) st = m_id_b;
        else if (c.op == op_scalar_mul) st = m_scalar;
        else st = m_done;
      end else if (st == m_id_b) begin
        byte_v = 8'($urandom_range(0, rx_id_limit - 1));
        press(8'h00, 8'h00, byte_v, 1'b1, 1'b0, 1'b0);
        c.id_b = mat_id_w'(byte_v);
        st     = m_done;
      end else begin
        sw = 8'($urandom);
        press(8'h00, sw, 8'h00, 1'b0, 1'b1, 1'b0);  // Scalar confirm
        c.scalar = to_twos(sw);
        st       = m_done;
      end
    end
    c.dims = cur_dims;
    exp_q.push_back(c);
  endtask

  // ==========================================================================
  // ALU model and dispatch checker
  // ==========================================================================
  initial begin : alu_model
    calc_cmd_t c;
    int        delay;
    bit        answer_err;
    alu_done <= 1'b0;
    alu_err  <= 1'b0;
    forever begin
      while (exp_q.size() == 0) @(negedge clk);
      c = exp_q.pop_front();
      while (!alu_start && err_count == 8'(n_err)) @(negedge clk);
      if (dims_pass(c)) begin
        n_passed++;
        check_eq("alu_start", 32'd1, 32'(alu_start));
        check_eq("err_count before start", 32'(8'(n_err)), 32'(err_count));
        check_eq("alu_op", 32'(c.op), 32'(alu_op));
        check_eq("alu_id_a", 32'(c.id_a), 32'(alu_id_a));
        check_eq("alu_id_b", 32'(c.id_b), 32'(alu_id_b));
        check_eq("alu_scalar", 32'(c.scalar), 32'(alu_scalar));
        delay      = fast_mode ? max_delay : $urandom_range(1, max_delay);
        answer_err = !fast_mode && ($urandom_range(0, 7) == 0);
        repeat (delay) @(posedge clk);
        if (answer_err) alu_err <= 1'b1;
        else alu_done <= 1'b1;
        @(posedge clk);
        alu_done <= 1'b0;
        alu_err  <= 1'b0;
        @(negedge clk);
        if (answer_err) begin
          n_err++;
          check_eq("err_count after alu_err", 32'(8'(n_err)), 32'(err_count));
          check_eq("calc_err after alu_err", 32'd1, 32'(calc_err));
        end else begin
          n_done++;
          check_eq("done_count", 32'(8'(n_done)), 32'(done_count));
          check_eq("last_cycles", 32'(delay + 1), 32'(last_cycles));  // Start edge counts
        end
      end else begin
        n_err++;
        check_eq("alu_start on rejected shape", 32'd0, 32'(alu_start));
        check_eq("err_count after reject", 32'(8'(n_err)), 32'(err_count));
        check_eq("calc_err after reject", 32'd1, 32'(calc_err));
      end
      n_checked++;
    end
  end

  initial begin : watchdog
    repeat ((n_rand + n_fast) * cycles_per_cmd + 500) @(posedge clk);
    $display("Timeout, the DUT stopped dispatching before all commands were checked");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin : stimulus
    void'($urandom(seed));
    rst_n       <= 1'b0;
    sw_mode_sel <= '0;
    scalar_sw   <= '0;
    rx_data     <= '0;
    rx_done     <= 1'b0;
    btn_confirm <= 1'b0;
    btn_esc     <= 1'b0;
    a_rows      <= '0;
    a_cols      <= '0;
    b_rows      <= '0;
    b_cols      <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("entry_busy after reset", 32'd0, 32'(entry_busy));
    check_eq("done_count after reset", 32'd0, 32'(done_count));
    check_eq("err_count after reset", 32'd0, 32'(err_count));

    test_name = "random_entry";
    repeat (n_rand) enter_command();
    while (n_checked < n_rand) @(negedge clk);

    test_name = "backpressure";
    fast_mode = 1'b1;
    saw_stall = 1'b0;
    repeat (n_fast) enter_command();
    while (n_checked < n_rand + n_fast) @(negedge clk);
    repeat (8) @(negedge clk);  // A duplicated queue entry would dispatch by now
    check_eq("entry stalled on full queue", 32'd1, 32'(saw_stall));
    check_eq("alu_start pulses", 32'(n_passed), 32'(n_started));
    check_eq("final done_count", 32'(8'(n_done)), 32'(done_count));
    check_eq("final err_count", 32'(8'(n_err)), 32'(err_count));
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- vlog.f
design/calc_pkg.sv
design/calc_cmd_if.sv
design/cmd_entry.sv
design/cmd_queue.sv
design/alu_dispatch.sv
design/matrix_calc_ctrl.sv
test/calc_ctrl_assert.sv
test/tb_matrix_calc_ctrl.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status is the test result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f vlog.f --top-module tb_matrix_calc_ctrl -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
